//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_sd_dat_tx
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
+incdir+include
design/sd_tx_pkg.sv
design/sd_tx_ifc.sv
design/crc16.sv
design/sd_bit_counter.sv
design/sd_tx_fsm.sv
design/sd_tx_shifter.sv
design/sd_dat_tx.sv
tb/tb_sd_dat_tx.sv

//--- design/crc16.sv
// serial crc16 engine for the sd data line
// one lfsr step per enabled bit, msb of the stream first
`timescale 1ns/1ps
`include "sd_tx_macros.svh"

module crc16 #(
  parameter logic [15:0] POLYNOMIAL = `SD_CRC_POLY,
  parameter logic [15:0] SEED       = `SD_CRC_SEED
) (
  input logic   clk,
  input logic   rst,
  crc_if.engine crc_bus
);

  logic        fb;
  logic [15:0] crc_q;

  // feedback, incoming bit against the register top
  assign fb = crc_bus.din ^ crc_q[15];

  always_ff @(posedge clk) begin
    if (rst || crc_bus.clear) begin
      crc_q <= SEED;
    end else if (crc_bus.en) begin
      // shift left, fold in taps when feedback set
      // taps land on bits 12, 5 and 0 for 0x1021
      crc_q <= {crc_q[14:0], 1'b0} ^ (fb ? POLYNOMIAL : 16'h0000);
    end
  end

  // running value, final once the last data bit is in
  assign crc_bus.crc = crc_q;

  // fsm clears at frame accept and feeds only in later cycles
  // overlap would drop the first data bit from the sum
  a_clear_en_excl: assert property (
    @(posedge clk) disable iff (rst)
    !(crc_bus.clear && crc_bus.en)
  ) else $error("crc16: clear and en high in the same cycle");

endmodule

//--- design/sd_bit_counter.sv
// phase bit counter for the sd data transmitter
// loaded with a phase length minus one, counts down, flags the last bit
`timescale 1ns/1ps

module sd_bit_counter (
  input logic    clk,
  input logic    rst,
  cnt_if.counter cnt_bus
);

  logic [7:0] cnt_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= 8'd0;
    end else if (cnt_bus.load) begin
      // load wins over tick at a phase boundary
      cnt_q <= cnt_bus.len;
    end else if (cnt_bus.tick) begin
      cnt_q <= cnt_q - 8'd1;
    end
  end

  assign cnt_bus.cnt = cnt_q;

  // zero means the bit placed this cycle ends the phase
  assign cnt_bus.last = (cnt_q == 8'd0);

  // fsm must reload or stop at zero, never wrap
  a_no_underflow: assert property (
    @(posedge clk) disable iff (rst)
    (cnt_bus.tick && cnt_bus.last) |-> cnt_bus.load
  ) else $error("sd_bit_counter: tick at zero without load");

endmodule

//--- design/sd_dat_tx.sv
// sd card single dat line write path
// start bit, msb-first block, crc16, end bit, one bit per clk
`timescale 1ns/1ps
`include "sd_tx_macros.svh"

module sd_dat_tx
  import sd_tx_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        start,
  input  logic [7:0]  byte_data,
  output logic        byte_take,
  output logic        dat,
  output logic        busy,
  output logic        done,
  output logic [15:0] crc
);

  crc_if crc_bus ();
  cnt_if cnt_bus ();

  line_op_e line_op;
  logic     load_byte;
  logic     load_crc;
  logic     shift_en;

  crc16 #(
    .POLYNOMIAL (`SD_CRC_POLY),
    .SEED       (`SD_CRC_SEED)
  ) u_crc16 (
    .clk     (clk),
    .rst     (rst),
    .crc_bus (crc_bus.engine)
  );

  sd_bit_counter u_counter (
    .clk     (clk),
    .rst     (rst),
    .cnt_bus (cnt_bus.counter)
  );

  sd_tx_fsm #(
    .BLOCK_BYTES (`SD_BLOCK_BYTES)
  ) u_fsm (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .busy      (busy),
    .done      (done),
    .byte_take (byte_take),
    .load_byte (load_byte),
    .load_crc  (load_crc),
    .shift_en  (shift_en),
    .line_op   (line_op),
    .crc_bus   (crc_bus.ctrl),
    .cnt_bus   (cnt_bus.ctrl)
  );

  sd_tx_shifter u_shifter (
    .clk       (clk),
    .rst       (rst),
    .byte_data (byte_data),
    .load_byte (load_byte),
    .load_crc  (load_crc),
    .shift_en  (shift_en),
    .line_op   (line_op),
    .crc_bus   (crc_bus.feed),
    .crc_in    (crc_bus.crc),
    .dat       (dat)
  );

  // held from the last data bit until the next accepted start
  assign crc = crc_bus.crc;

endmodule

//--- design/sd_tx_fsm.sv
// frame sequencer for the sd data line transmitter
// orders start, data, crc and end bits, steers counter, shifter and crc
`timescale 1ns/1ps
`include "sd_tx_macros.svh"

module sd_tx_fsm
  import sd_tx_pkg::*;
#(
  parameter int BLOCK_BYTES = `SD_BLOCK_BYTES
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     start,
  output logic     busy,
  output logic     done,
  output logic     byte_take,
  output logic     load_byte,
  output logic     load_crc,
  output logic     shift_en,
  output line_op_e line_op,
  crc_if.ctrl      crc_bus,
  cnt_if.ctrl      cnt_bus
);

  localparam logic [7:0] DATA_LEN    = 8'(BLOCK_BYTES * 8 - 1);
  localparam logic [7:0] CRC_LEN     = 8'd15;
  localparam int         DATA_CYCLES = BLOCK_BYTES * 8;

  tx_state_e state_q;
  tx_state_e state_d;
  logic      accept;
  logic      next_byte;

  // start only from idle; done cycle still counts as the tail of a frame
  assign accept = (state_q == ST_IDLE) && start && !done;

  // low bits at 1 -> last bit of the current byte placed now
  // swap in the next byte at this edge, except after the final byte
  assign next_byte = (state_q == ST_DATA) && (cnt_bus.cnt[2:0] == 3'd1) &&
                     (cnt_bus.cnt != 8'd1);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:  if (accept) state_d = ST_START;
      ST_START: state_d = ST_DATA;
      ST_DATA:  if (cnt_bus.last) state_d = ST_CRC;
      ST_CRC:   if (cnt_bus.last) state_d = ST_END;
      ST_END:   state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      busy    <= 1'b0;
      done    <= 1'b0;
    end else begin
      state_q <= state_d;
      busy    <= (state_d != ST_IDLE);
      // one cycle after the end bit
      done    <= (state_q == ST_END);
    end
  end

  // line command leads the line by one cycle, so it follows the next state
  always_comb begin
    case (state_d)
      ST_START:        line_op = LINE_START;
      ST_DATA, ST_CRC: line_op = LINE_SHIFT;
      ST_END:          line_op = LINE_END;
      default:         line_op = LINE_IDLE;
    endcase
  end

  // byte 0 at accept, then every 8 bits
  assign byte_take = accept || next_byte;
  assign load_byte = byte_take;
  // crc complete after the last data bit, snapshot on the data-to-crc step
  assign load_crc  = (state_q == ST_DATA) && cnt_bus.last;
  assign shift_en  = (line_op == LINE_SHIFT);

  // fresh seed per frame, one step per data bit placed
  assign crc_bus.clear = accept;
  assign crc_bus.en    = (state_d == ST_DATA);

  // data length loaded in start, crc length at the data/crc boundary
  assign cnt_bus.load = (state_q == ST_START) || load_crc;
  assign cnt_bus.len  = (state_q == ST_START) ? DATA_LEN : CRC_LEN;
  assign cnt_bus.tick = ((state_q == ST_DATA) || (state_q == ST_CRC)) && !cnt_bus.last;

  // data phase spans one cycle per block bit, right after the start bit
  a_data_span: assert property (
    @(posedge clk) disable iff (rst)
    (state_q == ST_CRC) && ($past(state_q) == ST_DATA) |->
      ($past(state_q, DATA_CYCLES + 1) == ST_START)
  ) else $error("sd_tx_fsm: data phase length wrong");

  // sixteen crc bits between the data phase and the end bit
  a_crc_span: assert property (
    @(posedge clk) disable iff (rst)
    (state_q == ST_END) |->
      ($past(state_q, 16) == ST_CRC) && ($past(state_q, 17) == ST_DATA)
  ) else $error("sd_tx_fsm: crc phase length wrong");

endmodule

//--- design/sd_tx_ifc.sv
// internal buses of the sd data transmitter
// crc_if joins fsm, shifter and crc engine; cnt_if joins fsm and counter
`timescale 1ns/1ps

interface crc_if;
  logic        clear;
  logic        en;
  logic        din;
  logic [15:0] crc;

  // fsm clears per frame and enables per data bit
  modport ctrl (output clear, output en);
  // shifter supplies the bit going out
  modport feed (output din);
  modport engine (input clear, input en, input din, output crc);
endinterface

interface cnt_if;
  logic       load;
  logic [7:0] len;
  logic       tick;
  logic [7:0] cnt;
  logic       last;

  // len is phase length minus one
  modport ctrl (output load, output len, output tick, input cnt, input last);
  modport counter (input load, input len, input tick, output cnt, output last);
endinterface

//--- design/sd_tx_pkg.sv
// sd data line transmitter types
// frame states and the per-cycle line command
package sd_tx_pkg;

  // frame phases, one per segment on the line
  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_START = 3'd1,
    ST_DATA  = 3'd2,
    ST_CRC   = 3'd3,
    ST_END   = 3'd4
  } tx_state_e;

  // what the shifter puts on dat at the next edge
  typedef enum logic [1:0] {
    LINE_IDLE  = 2'd0,
    LINE_START = 2'd1,
    LINE_SHIFT = 2'd2,
    LINE_END   = 2'd3
  } line_op_e;

endpackage

//--- design/sd_tx_shifter.sv
// dat line shifter for the sd data transmitter
// holds the current byte or the crc snapshot, drives a registered dat
`timescale 1ns/1ps

module sd_tx_shifter
  import sd_tx_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [7:0]  byte_data,
  input  logic        load_byte,
  input  logic        load_crc,
  input  logic        shift_en,
  input  line_op_e    line_op,
  crc_if.feed         crc_bus,
  input  logic [15:0] crc_in,
  output logic        dat
);

  logic [15:0] sreg;
  logic        out_bit;

  // byte sits in the top half, low half only fills with zeros
  always_ff @(posedge clk) begin
    if (load_byte) begin
      sreg <= {byte_data, 8'h00};
    end else if (load_crc) begin
      // crc[15] goes straight to the line this cycle
      // keep the rest already shifted by one
      sreg <= {crc_in[14:0], 1'b0};
    end else if (shift_en) begin
      sreg <= {sreg[14:0], 1'b0};
    end
  end

  // first crc bit bypasses the register on the snapshot cycle
  assign out_bit = load_crc ? crc_in[15] : sreg[15];

  always_ff @(posedge clk) begin
    if (rst) begin
      dat <= 1'b1;
    end else begin
      case (line_op)
        LINE_START: dat <= 1'b0;
        LINE_SHIFT: dat <= out_bit;
        // idle and end bit both high
        default:    dat <= 1'b1;
      endcase
    end
  end

  // crc sees each data bit as it is placed
  assign crc_bus.din = sreg[15];

endmodule

//--- include/sd_tx_macros.svh
// sd data line transmitter, shared build-time values
// frame length and crc16 defaults
`ifndef SD_TX_MACROS_SVH
`define SD_TX_MACROS_SVH

// data bytes per frame, 32 at most for the 8-bit phase counter
`define SD_BLOCK_BYTES 8

// crc16 ccitt form, x^16 + x^12 + x^5 + 1
`define SD_CRC_POLY 16'h1021

// sd data crc starts from zero
`define SD_CRC_SEED 16'h0000

`endif

//--- tb/sd_tx_tests.hex
// columns: data byte 0 to data byte 7, then expected crc16 high byte and low byte
// one frame per line, crc over the data bits msb first from seed 0
00 00 00 00 00 00 00 00 00 00
FF FF FF FF FF FF FF FF A6 E1
00 00 00 00 00 00 00 00 00 00
01 02 03 04 05 06 07 08 76 AC
80 00 00 00 00 00 00 00 FD 81
00 00 00 00 00 00 00 01 10 21
00 00 00 00 00 00 00 80 91 88
00 00 00 00 00 00 00 FF 1E F0
00 00 00 00 00 00 A5 5A 19 34
00 00 00 00 00 01 10 21 00 00
FF FF FF FF FF FF 97 DF 00 00
01 02 03 04 05 06 D9 0C 00 00
00 00 00 01 02 03 04 05 82 08
00 FF FF FF FF FF FF FF 32 AE
00 00 00 80 00 00 00 00 22 D0
00 00 00 00 00 FF FF FF D2 6C

//--- tb/tb_sd_dat_tx.sv
// testbench for the sd dat line transmitter
// replays frames from the vector file and checks every line bit,
// the strobes and the crc port, with random gaps and stray starts
`timescale 1ns/1ps
`include "sd_tx_macros.svh"

module tb_sd_dat_tx;

  localparam int N         = `SD_BLOCK_BYTES;
  localparam int BITS      = 8 * N;
  localparam int NUM_TESTS = 16;
  // data bytes plus two crc bytes
  localparam int WORDS     = N + 2;
  // done cycle, counted from the accept edge
  localparam int FRAME_END = BITS + 19;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * (BITS + 30) + 100;

  logic        clk = 1'b0;
  logic        rst;
  logic        start;
  logic [7:0]  byte_data;
  logic        byte_take;
  logic        dat;
  logic        busy;
  logic        done;
  logic [15:0] crc;

  logic [7:0]  vec_mem [0:255];
  logic [7:0]  lfsr_state = 8'd96;
  int          cycle_cnt = 0;

  sd_dat_tx dut_i (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .byte_data (byte_data),
    .byte_take (byte_take),
    .dat       (dat),
    .busy      (busy),
    .done      (done),
    .crc       (crc)
  );

  always #4 clk = ~clk;

  // run limit from the frame count
  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: %0d cycles passed and the frames did not finish", cycle_cnt);
    $display("Simulation finished: FAIL");
    $fatal(1);
  end

  // x^8 + x^6 + x^5 + x^4 + 1, new bit enters at the bottom
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic draw_bits(input int n, output int val);
    int i;
    val = 0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = (val << 1) | int'(lfsr_state[0]);
    end
  endtask

  function automatic logic [7:0] vec_byte(input int idx);
    return vec_mem[8'(idx)];
  endfunction

  // bit j of the frame, msb of byte 0 first
  function automatic logic data_bit(input int t, input int j);
    logic [7:0] b;
    b = vec_byte(t * WORDS + j / 8) << (j % 8);
    return b[7];
  endfunction

  function automatic logic [15:0] file_crc(input int t);
    return {vec_byte(t * WORDS + N), vec_byte(t * WORDS + N + 1)};
  endfunction

  // bitwise crc16, feedback is data bit xor top bit
  function automatic logic [15:0] ref_crc(input int t);
    logic [15:0] c;
    logic        fb;
    int          j;
    c = `SD_CRC_SEED;
    for (j = 0; j < BITS; j++) begin
      fb = data_bit(t, j) ^ c[15];
      c = {c[14:0], 1'b0};
      if (fb) begin
        c = c ^ `SD_CRC_POLY;
      end
    end
    return c;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s got %0h exp %0h", name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  endtask

  task automatic next_drive;
    @(posedge clk);
    #1;
  endtask

  // line parked high, crc port holds the last frame value
  task automatic check_idle(input logic [15:0] exp_crc);
    check_val("dat", 32'(dat), 32'd1);
    check_val("busy", 32'(busy), 32'd0);
    check_val("done", 32'(done), 32'd0);
    check_val("byte_take", 32'(byte_take), 32'd0);
    check_val("crc", 32'(crc), 32'(exp_crc));
  endtask

  task automatic run_frame(input int t);
    int          rel;
    int          next_idx;
    int          coin;
    int          slot;
    int          extra_rel;
    logic        advance;
    logic        exp_dat;
    logic [15:0] exp_crc;
    exp_crc = file_crc(t);
    check_val("ref_crc", 32'(ref_crc(t)), 32'(exp_crc));
    draw_bits(1, coin);
    draw_bits(6, slot);
    // stray start inside the busy window, or none
    extra_rel = (coin == 1) ? slot + 2 : -1;
    next_drive();
    byte_data = vec_byte(t * WORDS);
    start = 1'b1;
    @(negedge clk);
    // accept cycle, byte 0 taken at this edge
    check_val("byte_take", 32'(byte_take), 32'd1);
    check_val("busy", 32'(busy), 32'd0);
    next_idx = 1;
    advance = 1'b1;
    for (rel = 1; rel <= FRAME_END; rel++) begin
      next_drive();
      start = (rel == extra_rel);
      if (advance && next_idx < N) begin
        byte_data = vec_byte(t * WORDS + next_idx);
        next_idx++;
      end
      advance = 1'b0;
      @(negedge clk);
      if (rel == 1) begin
        exp_dat = 1'b0;
      end else if (rel <= BITS + 1) begin
        exp_dat = data_bit(t, rel - 2);
      end else if (rel <= BITS + 17) begin
        // crc[15] first
        exp_dat = exp_crc[4'(BITS + 17 - rel)];
      end else begin
        exp_dat = 1'b1;
      end
      check_val("dat", 32'(dat), 32'(exp_dat));
      check_val("busy", 32'(busy), 32'(rel <= BITS + 18));
      check_val("done", 32'(done), 32'(rel == FRAME_END));
      check_val("byte_take", 32'(byte_take), 32'((rel % 8 == 0) && (rel < BITS)));
      if (byte_take) begin
        advance = 1'b1;
      end
      if (rel >= BITS + 2) begin
        check_val("crc", 32'(crc), 32'(exp_crc));
      end
    end
  endtask

  initial begin
    int t;
    int gap;
    int i;
    rst = 1'b1;
    start = 1'b0;
    byte_data = 8'h00;
    for (i = 0; i < 256; i++) begin
      vec_mem[8'(i)] = 8'(i * 29 + 90);
    end
    $readmemh("tb/sd_tx_tests.hex", vec_mem);
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_idle(16'h0000);
    for (t = 0; t < NUM_TESTS; t++) begin
      run_frame(t);
      // zero gap gives back to back frames
      draw_bits(2, gap);
      repeat (gap) begin
        next_drive();
        @(negedge clk);
        check_idle(file_crc(t));
      end
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
